// File: csr_pkg.sv
package csr_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 4;

    typedef logic [XLEN-1:0]  data_t;
    typedef logic [XLEN-1:0]  pc_t;
    typedef logic [11:0]      csr_addr_t;
    typedef logic [4:0]       exc_code_t;
    typedef logic [TAG_W-1:0] tag_t;

    // code 16 is reserved by the privileged spec, so it is free to mark an mret.
    localparam exc_code_t EXC_MRET = 5'd16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal register slots and spec addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [4:0] {
        CSR_MVENDORID,
        CSR_MARCHID,
        CSR_MIMPID,
        CSR_MHARTID,
        CSR_MISA,
        CSR_MSTATUS,
        CSR_MSTATUSH,
        CSR_MIE,
        CSR_MTVEC,
        CSR_MEPC,
        CSR_MCAUSE,
        CSR_MTVAL,
        CSR_MTINST,
        CSR_MCYCLE,
        CSR_MCYCLEH,
        CSR_MINSTRET,
        CSR_MINSTRETH,
        CSR_NONE
    } csr_idx_e;

    localparam csr_addr_t CSR_ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_ADDR_MHARTID   = 12'hF14;
    localparam csr_addr_t CSR_ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA      = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIE       = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSTATUSH  = 12'h310;
    localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_ADDR_MTINST    = 12'h34A;
    localparam csr_addr_t CSR_ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_ADDR_MINSTRETH = 12'hB82;

    // mpp is two bits wide and starts at this position.
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

    localparam logic [1:0] PRIV_M = 2'b11;

    // mxl = 1 (32-bit), with the c, i and m extensions.
    localparam data_t MISA_RESET = 32'h4000_1104;

    typedef struct packed {
        pc_t       pc;
        exc_code_t code;
        data_t     info;
    } exc_report_t;

    typedef struct packed {
        csr_addr_t addr;
        tag_t      tag;
    } csr_rd_req_t;

    typedef struct packed {
        csr_addr_t addr;
        tag_t      tag;
        data_t     data;
    } csr_wr_req_t;

    typedef struct packed {
        exc_report_t exc;
        logic        valid;
        logic        is_mret;
    } trap_sel_t;

    function automatic csr_idx_e csr_to_idx(csr_addr_t addr);
        case (addr)
            CSR_ADDR_MVENDORID: return CSR_MVENDORID;
            CSR_ADDR_MARCHID:   return CSR_MARCHID;
            CSR_ADDR_MIMPID:    return CSR_MIMPID;
            CSR_ADDR_MHARTID:   return CSR_MHARTID;
            CSR_ADDR_MSTATUS:   return CSR_MSTATUS;
            CSR_ADDR_MISA:      return CSR_MISA;
            CSR_ADDR_MIE:       return CSR_MIE;
            CSR_ADDR_MTVEC:     return CSR_MTVEC;
            CSR_ADDR_MSTATUSH:  return CSR_MSTATUSH;
            CSR_ADDR_MEPC:      return CSR_MEPC;
            CSR_ADDR_MCAUSE:    return CSR_MCAUSE;
            CSR_ADDR_MTVAL:     return CSR_MTVAL;
            CSR_ADDR_MTINST:    return CSR_MTINST;
            CSR_ADDR_MCYCLE:    return CSR_MCYCLE;
            CSR_ADDR_MINSTRET:  return CSR_MINSTRET;
            CSR_ADDR_MCYCLEH:   return CSR_MCYCLEH;
            CSR_ADDR_MINSTRETH: return CSR_MINSTRETH;
            default:            return CSR_NONE;
        endcase
    endfunction

endpackage

// File: csr_trap_arbiter.sv
`timescale 1ns/1ps

module csr_trap_arbiter (
    input  csr_pkg::exc_report_t dec_exc_i,
    input  logic                 dec_valid_i,
    input  csr_pkg::exc_report_t exe_exc_i,
    input  logic                 exe_valid_i,
    input  csr_pkg::exc_report_t mem_exc_i,
    input  logic                 mem_valid_i,
    output csr_pkg::trap_sel_t   trap_o
);

    csr_pkg::exc_report_t winner;
    logic                 any_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed priority, oldest stage first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the younger reports are simply dropped, their instructions get flushed anyway.
    always_comb begin
        winner = '0;
        if (mem_valid_i) begin
            winner = mem_exc_i;
        end else if (exe_valid_i) begin
            winner = exe_exc_i;
        end else if (dec_valid_i) begin
            winner = dec_exc_i;
        end
    end

    assign any_valid = mem_valid_i | exe_valid_i | dec_valid_i;

    always_comb begin
        trap_o         = '0;
        trap_o.exc     = winner;
        trap_o.valid   = any_valid;
        // an mret travels on the same path, marked by its reserved code.
        trap_o.is_mret = any_valid && (winner.code == csr_pkg::EXC_MRET);
    end

endmodule

// File: csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 retire_i,
    input  csr_pkg::csr_wr_req_t wr_req_i,
    input  logic                 wr_valid_i,
    output csr_pkg::data_t       mcycle_o,
    output csr_pkg::data_t       mcycleh_o,
    output csr_pkg::data_t       minstret_o,
    output csr_pkg::data_t       minstreth_o
);

    csr_pkg::csr_idx_e wr_idx;

    logic [63:0] mcycle_q;
    logic [63:0] mcycle_d;
    logic [63:0] minstret_q;
    logic [63:0] minstret_d;

    // the low half carries into the high half only when it wraps.
    function automatic logic [63:0] inc64(logic [63:0] value, logic en);
        logic [32:0] lo_sum;
        logic [31:0] hi_sum;
        lo_sum = {1'b0, value[31:0]} + {32'b0, en};
        hi_sum = value[63:32] + {31'b0, lo_sum[32]};
        return {hi_sum, lo_sum[31:0]};
    endfunction

    assign wr_idx = csr_pkg::csr_to_idx(wr_req_i.addr);

    // a write to either half replaces it and skips that counter's increment.
    always_comb begin
        mcycle_d   = inc64(mcycle_q, 1'b1);
        minstret_d = inc64(minstret_q, retire_i);
        if (wr_valid_i) begin
            case (wr_idx)
                csr_pkg::CSR_MCYCLE:    mcycle_d   = {mcycle_q[63:32], wr_req_i.data};
                csr_pkg::CSR_MCYCLEH:   mcycle_d   = {wr_req_i.data, mcycle_q[31:0]};
                csr_pkg::CSR_MINSTRET:  minstret_d = {minstret_q[63:32], wr_req_i.data};
                csr_pkg::CSR_MINSTRETH: minstret_d = {wr_req_i.data, minstret_q[31:0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= mcycle_d;
            minstret_q <= minstret_d;
        end
    end

    assign mcycle_o    = mcycle_q[31:0];
    assign mcycleh_o   = mcycle_q[63:32];
    assign minstret_o  = minstret_q[31:0];
    assign minstreth_o = minstret_q[63:32];

endmodule

// File: csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile #(
    parameter csr_pkg::data_t HART_ID     = 32'h0000_0000,
    parameter csr_pkg::pc_t   MTVEC_RESET = 32'h0000_0100
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  csr_pkg::trap_sel_t   trap_i,
    input  csr_pkg::csr_rd_req_t rd_req_i,
    input  logic                 rd_reserve_i,
    input  csr_pkg::csr_wr_req_t wr_req_i,
    input  logic                 wr_valid_i,
    input  csr_pkg::data_t       cnt_mcycle_i,
    input  csr_pkg::data_t       cnt_mcycleh_i,
    input  csr_pkg::data_t       cnt_minstret_i,
    input  csr_pkg::data_t       cnt_minstreth_i,
    output logic                 cnt_wr_valid_o,
    output csr_pkg::data_t       rd_data_o,
    output logic                 rd_ready_o,
    output logic                 flush_o,
    output csr_pkg::pc_t         redirect_pc_o,
    output logic                 redirect_valid_o
);

    localparam int N_SLOT = int'(csr_pkg::CSR_NONE);

    typedef struct packed {
        csr_pkg::data_t mstatus;
        csr_pkg::data_t mstatush;
        csr_pkg::data_t mie;
        csr_pkg::pc_t   mtvec;
        csr_pkg::pc_t   mepc;
        csr_pkg::data_t mcause;
        csr_pkg::data_t mtval;
        csr_pkg::data_t mtinst;
    } mregs_t;

    mregs_t regs_q;
    mregs_t regs_d;

    csr_pkg::tag_t     tag_q [N_SLOT];
    csr_pkg::tag_t     tag_d [N_SLOT];
    logic [N_SLOT-1:0] ready_q;
    logic [N_SLOT-1:0] ready_d;

    csr_pkg::csr_idx_e rd_idx;
    csr_pkg::csr_idx_e wr_idx;
    logic              wr_ok;

    // only slots that a write can reach take part in the scoreboard.
    function automatic logic slot_writable(csr_pkg::csr_idx_e idx);
        case (idx)
            csr_pkg::CSR_MSTATUS,
            csr_pkg::CSR_MSTATUSH,
            csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC,
            csr_pkg::CSR_MEPC,
            csr_pkg::CSR_MCAUSE,
            csr_pkg::CSR_MTVAL,
            csr_pkg::CSR_MTINST,
            csr_pkg::CSR_MCYCLE,
            csr_pkg::CSR_MCYCLEH,
            csr_pkg::CSR_MINSTRET,
            csr_pkg::CSR_MINSTRETH: return 1'b1;
            default:                return 1'b0;
        endcase
    endfunction

    assign rd_idx = csr_pkg::csr_to_idx(rd_req_i.addr);
    assign wr_idx = csr_pkg::csr_to_idx(wr_req_i.addr);

    // the instruction behind a write is flushed when a trap fires in the same cycle.
    assign wr_ok          = wr_valid_i && !trap_i.valid;
    assign cnt_wr_valid_o = wr_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state of registers and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        regs_d  = regs_q;
        tag_d   = tag_q;
        ready_d = ready_q;

        if (wr_ok && slot_writable(wr_idx)) begin
            case (wr_idx)
                csr_pkg::CSR_MSTATUS:  regs_d.mstatus  = wr_req_i.data;
                csr_pkg::CSR_MSTATUSH: regs_d.mstatush = wr_req_i.data;
                csr_pkg::CSR_MIE:      regs_d.mie      = wr_req_i.data;
                csr_pkg::CSR_MTVEC:    regs_d.mtvec    = wr_req_i.data;
                csr_pkg::CSR_MEPC:     regs_d.mepc     = wr_req_i.data;
                csr_pkg::CSR_MCAUSE:   regs_d.mcause   = wr_req_i.data;
                csr_pkg::CSR_MTVAL:    regs_d.mtval    = wr_req_i.data;
                csr_pkg::CSR_MTINST:   regs_d.mtinst   = wr_req_i.data;
                default: ;
            endcase
            if (tag_q[wr_idx] == wr_req_i.tag) begin
                ready_d[wr_idx] = 1'b1;
            end
        end

        // a reservation in the same cycle wins over the write's ready update.
        if (rd_reserve_i && slot_writable(rd_idx)) begin
            tag_d[rd_idx]   = rd_req_i.tag;
            ready_d[rd_idx] = 1'b0;
        end

        if (trap_i.valid) begin
            if (trap_i.is_mret) begin
                regs_d.mstatus[csr_pkg::MSTATUS_MIE]  = regs_q.mstatus[csr_pkg::MSTATUS_MPIE];
                regs_d.mstatus[csr_pkg::MSTATUS_MPIE] = 1'b1;
            end else begin
                regs_d.mepc   = trap_i.exc.pc;
                regs_d.mcause = csr_pkg::data_t'(trap_i.exc.code);
                regs_d.mtval  = trap_i.exc.info;
                regs_d.mstatus[csr_pkg::MSTATUS_MPIE]     = regs_q.mstatus[csr_pkg::MSTATUS_MIE];
                regs_d.mstatus[csr_pkg::MSTATUS_MIE]      = 1'b0;
                regs_d.mstatus[csr_pkg::MSTATUS_MPP +: 2] = csr_pkg::PRIV_M;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            regs_q  <= '{mtvec: MTVEC_RESET, default: '0};
            ready_q <= '1;
            for (int i = 0; i < N_SLOT; i++) begin
                tag_q[i] <= '0;
            end
        end else begin
            regs_q  <= regs_d;
            ready_q <= ready_d;
            tag_q   <= tag_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port and redirect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (rd_idx)
            csr_pkg::CSR_MHARTID:   rd_data_o = HART_ID;
            csr_pkg::CSR_MISA:      rd_data_o = csr_pkg::MISA_RESET;
            csr_pkg::CSR_MSTATUS:   rd_data_o = regs_q.mstatus;
            csr_pkg::CSR_MSTATUSH:  rd_data_o = regs_q.mstatush;
            csr_pkg::CSR_MIE:       rd_data_o = regs_q.mie;
            csr_pkg::CSR_MTVEC:     rd_data_o = regs_q.mtvec;
            csr_pkg::CSR_MEPC:      rd_data_o = regs_q.mepc;
            csr_pkg::CSR_MCAUSE:    rd_data_o = regs_q.mcause;
            csr_pkg::CSR_MTVAL:     rd_data_o = regs_q.mtval;
            csr_pkg::CSR_MTINST:    rd_data_o = regs_q.mtinst;
            csr_pkg::CSR_MCYCLE:    rd_data_o = cnt_mcycle_i;
            csr_pkg::CSR_MCYCLEH:   rd_data_o = cnt_mcycleh_i;
            csr_pkg::CSR_MINSTRET:  rd_data_o = cnt_minstret_i;
            csr_pkg::CSR_MINSTRETH: rd_data_o = cnt_minstreth_i;
            // vendor, arch and impl ids read as zero, as do unknown addresses.
            default:                rd_data_o = '0;
        endcase
    end

    assign rd_ready_o = (rd_idx == csr_pkg::CSR_NONE) ? 1'b1 : ready_q[rd_idx];

    // the redirect uses the values held before this cycle's update.
    assign flush_o          = trap_i.valid;
    assign redirect_valid_o = trap_i.valid;
    assign redirect_pc_o    = trap_i.is_mret ? regs_q.mepc : regs_q.mtvec;

endmodule

// File: csr_trap_unit.sv
`timescale 1ns/1ps

module csr_trap_unit #(
    parameter csr_pkg::data_t HART_ID     = 32'h0000_0000,
    parameter csr_pkg::pc_t   MTVEC_RESET = 32'h0000_0100
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  csr_pkg::exc_report_t dec_exc_i,
    input  logic                 dec_valid_i,
    input  csr_pkg::exc_report_t exe_exc_i,
    input  logic                 exe_valid_i,
    input  csr_pkg::exc_report_t mem_exc_i,
    input  logic                 mem_valid_i,

    input  csr_pkg::csr_rd_req_t rd_req_i,
    input  logic                 rd_reserve_i,
    input  csr_pkg::csr_wr_req_t wr_req_i,
    input  logic                 wr_valid_i,
    input  logic                 retire_i,

    output csr_pkg::data_t       rd_data_o,
    output logic                 rd_ready_o,
    output logic                 flush_o,
    output csr_pkg::pc_t         redirect_pc_o,
    output logic                 redirect_valid_o
);

    csr_pkg::trap_sel_t trap_sel;
    logic               cnt_wr_valid;
    csr_pkg::data_t     cnt_mcycle;
    csr_pkg::data_t     cnt_mcycleh;
    csr_pkg::data_t     cnt_minstret;
    csr_pkg::data_t     cnt_minstreth;

    csr_trap_arbiter u_arbiter (
        .dec_exc_i   (dec_exc_i),
        .dec_valid_i (dec_valid_i),
        .exe_exc_i   (exe_exc_i),
        .exe_valid_i (exe_valid_i),
        .mem_exc_i   (mem_exc_i),
        .mem_valid_i (mem_valid_i),
        .trap_o      (trap_sel)
    );

    csr_regfile #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .trap_i           (trap_sel),
        .rd_req_i         (rd_req_i),
        .rd_reserve_i     (rd_reserve_i),
        .wr_req_i         (wr_req_i),
        .wr_valid_i       (wr_valid_i),
        .cnt_mcycle_i     (cnt_mcycle),
        .cnt_mcycleh_i    (cnt_mcycleh),
        .cnt_minstret_i   (cnt_minstret),
        .cnt_minstreth_i  (cnt_minstreth),
        .cnt_wr_valid_o   (cnt_wr_valid),
        .rd_data_o        (rd_data_o),
        .rd_ready_o       (rd_ready_o),
        .flush_o          (flush_o),
        .redirect_pc_o    (redirect_pc_o),
        .redirect_valid_o (redirect_valid_o)
    );

    // counters see the write only after the register file has dropped trap-time writes.
    csr_counters u_counters (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .retire_i    (retire_i),
        .wr_req_i    (wr_req_i),
        .wr_valid_i  (cnt_wr_valid),
        .mcycle_o    (cnt_mcycle),
        .mcycleh_o   (cnt_mcycleh),
        .minstret_o  (cnt_minstret),
        .minstreth_o (cnt_minstreth)
    );

endmodule

// File: csr_trap_unit_chk.sv
`timescale 1ns/1ps

module csr_trap_unit_chk (
    input logic           clk_i,
    input logic           rstn_i,
    input logic           dec_valid_i,
    input logic           exe_valid_i,
    input logic           mem_valid_i,
    input csr_pkg::data_t rd_data_i,
    input logic           rd_ready_i,
    input logic           flush_i,
    input csr_pkg::pc_t   redirect_pc_i,
    input logic           redirect_valid_i
);

    int unsigned fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port rules of the trap unit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_flush_eq_redirect: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i == redirect_valid_i)
        else begin
            $error("flush_o and redirect_valid_o differ");
            fail_count++;
        end

    // a redirect needs a stage that reported something.
    a_redirect_has_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_i |-> (dec_valid_i || exe_valid_i || mem_valid_i))
        else begin
            $error("redirect_valid_o high without any stage report");
            fail_count++;
        end

    a_outputs_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({rd_data_i, rd_ready_i, flush_i, redirect_pc_i, redirect_valid_i}))
        else begin
            $error("an output of the trap unit is unknown");
            fail_count++;
        end

endmodule

// File: tb_csr_trap_unit.sv
`timescale 1ns/1ps

module tb_csr_trap_unit;

    localparam csr_pkg::data_t HART_ID     = 32'h0000_0002;
    localparam csr_pkg::pc_t   MTVEC_RESET = 32'h0000_0200;

    // six tests with budgets of 100, 600, 600, 300, 300 and 100 cycles.
    localparam int CYCLE_LIMIT = 2 * (100 + 600 + 600 + 300 + 300 + 100);

    // plain writable registers first, then counter halves, then read-only ids.
    localparam csr_pkg::csr_addr_t MAPPED [17] = '{
        csr_pkg::CSR_ADDR_MSTATUS, csr_pkg::CSR_ADDR_MSTATUSH, csr_pkg::CSR_ADDR_MIE,
        csr_pkg::CSR_ADDR_MTVEC, csr_pkg::CSR_ADDR_MEPC, csr_pkg::CSR_ADDR_MCAUSE,
        csr_pkg::CSR_ADDR_MTVAL, csr_pkg::CSR_ADDR_MTINST, csr_pkg::CSR_ADDR_MCYCLE,
        csr_pkg::CSR_ADDR_MCYCLEH, csr_pkg::CSR_ADDR_MINSTRET, csr_pkg::CSR_ADDR_MINSTRETH,
        csr_pkg::CSR_ADDR_MVENDORID, csr_pkg::CSR_ADDR_MARCHID, csr_pkg::CSR_ADDR_MIMPID,
        csr_pkg::CSR_ADDR_MHARTID, csr_pkg::CSR_ADDR_MISA
    };

    typedef struct packed {
        csr_pkg::data_t rd_data;
        logic           rd_ready;
        logic           redirect;
        csr_pkg::pc_t   redirect_pc;
    } expect_t;

    logic clk_i;
    logic rstn_i;
    csr_pkg::exc_report_t dec_exc, exe_exc, mem_exc;
    logic dec_valid, exe_valid, mem_valid;
    csr_pkg::csr_rd_req_t rd_req;
    csr_pkg::csr_wr_req_t wr_req;
    logic rd_reserve, wr_valid, retire;
    csr_pkg::data_t rd_data_o;
    logic rd_ready_o, flush_o, redirect_valid_o;
    csr_pkg::pc_t redirect_pc_o;

    // reference state, indexed by the spec address.
    csr_pkg::data_t regs_m  [4096];
    csr_pkg::tag_t  tag_m   [4096];
    logic           ready_m [4096];
    logic [63:0]    cycle_m;
    logic [63:0]    instret_m;

    logic [31:0] rng = 32'h1186;
    int err_cnt = 0;
    int err_mark = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;

    csr_trap_unit #(.HART_ID(HART_ID), .MTVEC_RESET(MTVEC_RESET)) u_dut (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .dec_exc_i(dec_exc), .dec_valid_i(dec_valid),
        .exe_exc_i(exe_exc), .exe_valid_i(exe_valid),
        .mem_exc_i(mem_exc), .mem_valid_i(mem_valid),
        .rd_req_i(rd_req), .rd_reserve_i(rd_reserve),
        .wr_req_i(wr_req), .wr_valid_i(wr_valid), .retire_i(retire),
        .rd_data_o(rd_data_o), .rd_ready_o(rd_ready_o), .flush_o(flush_o),
        .redirect_pc_o(redirect_pc_o), .redirect_valid_o(redirect_valid_o)
    );

    bind csr_trap_unit csr_trap_unit_chk u_chk (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .dec_valid_i(dec_valid_i), .exe_valid_i(exe_valid_i), .mem_valid_i(mem_valid_i),
        .rd_data_i(rd_data_o), .rd_ready_i(rd_ready_o), .flush_i(flush_o),
        .redirect_pc_i(redirect_pc_o), .redirect_valid_i(redirect_valid_o)
    );

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic plain_rw(csr_pkg::csr_addr_t a);
        for (int i = 0; i < 8; i++) begin
            if (MAPPED[i] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    // counter halves take part in the scoreboard as well.
    function automatic logic has_slot(csr_pkg::csr_addr_t a);
        for (int i = 0; i < 12; i++) begin
            if (MAPPED[i] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic csr_pkg::exc_report_t pick_winner();
        if (mem_valid) return mem_exc;
        if (exe_valid) return exe_exc;
        return dec_exc;
    endfunction

    function automatic expect_t expected_outputs();
        expect_t e;
        csr_pkg::csr_addr_t a;
        a = rd_req.addr;
        e.rd_ready = ready_m[a];
        case (a)
            csr_pkg::CSR_ADDR_MHARTID:   e.rd_data = HART_ID;
            csr_pkg::CSR_ADDR_MISA:      e.rd_data = csr_pkg::MISA_RESET;
            csr_pkg::CSR_ADDR_MCYCLE:    e.rd_data = cycle_m[31:0];
            csr_pkg::CSR_ADDR_MCYCLEH:   e.rd_data = cycle_m[63:32];
            csr_pkg::CSR_ADDR_MINSTRET:  e.rd_data = instret_m[31:0];
            csr_pkg::CSR_ADDR_MINSTRETH: e.rd_data = instret_m[63:32];
            default:                     e.rd_data = plain_rw(a) ? regs_m[a] : '0;
        endcase
        e.redirect = dec_valid || exe_valid || mem_valid;
        e.redirect_pc = (pick_winner().code == csr_pkg::EXC_MRET) ?
                        regs_m[csr_pkg::CSR_ADDR_MEPC] : regs_m[csr_pkg::CSR_ADDR_MTVEC];
        return e;
    endfunction

    task automatic check_data(input string name, input csr_pkg::data_t exp,
                              input csr_pkg::data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h at %0t", name, exp, act, $time);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h at %0t", name, exp, act, $time);
            err_cnt++;
        end
    endtask

    task automatic check_pc(input string name, input csr_pkg::pc_t exp, input csr_pkg::pc_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h at %0t", name, exp, act, $time);
            err_cnt++;
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
        dec_valid = 1'b0;
        exe_valid = 1'b0;
        mem_valid = 1'b0;
        rd_reserve = 1'b0;
        wr_valid = 1'b0;
        retire = 1'b0;
    endtask

    task automatic close_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d mismatches", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin : model
        csr_pkg::exc_report_t w;
        csr_pkg::data_t ms;
        logic trap, wr_ok;
        logic [63:0] cyc_n, ins_n;
        if (!rstn_i) begin
            for (int i = 0; i < 4096; i++) begin
                regs_m[i] = '0;
                tag_m[i] = '0;
                ready_m[i] = 1'b1;
            end
            regs_m[csr_pkg::CSR_ADDR_MTVEC] = MTVEC_RESET;
            cycle_m = '0;
            instret_m = '0;
        end else begin
            w = pick_winner();
            trap = dec_valid || exe_valid || mem_valid;
            wr_ok = wr_valid && !trap;
            cyc_n = cycle_m + 64'd1;
            ins_n = instret_m + {63'd0, retire};
            if (wr_ok) begin
                case (wr_req.addr)
                    csr_pkg::CSR_ADDR_MCYCLE:    cyc_n = {cycle_m[63:32], wr_req.data};
                    csr_pkg::CSR_ADDR_MCYCLEH:   cyc_n = {wr_req.data, cycle_m[31:0]};
                    csr_pkg::CSR_ADDR_MINSTRET:  ins_n = {instret_m[63:32], wr_req.data};
                    csr_pkg::CSR_ADDR_MINSTRETH: ins_n = {wr_req.data, instret_m[31:0]};
                    default: if (plain_rw(wr_req.addr)) regs_m[wr_req.addr] = wr_req.data;
                endcase
                if (has_slot(wr_req.addr) && tag_m[wr_req.addr] == wr_req.tag) begin
                    ready_m[wr_req.addr] = 1'b1;
                end
            end
            if (rd_reserve && has_slot(rd_req.addr)) begin
                tag_m[rd_req.addr] = rd_req.tag;
                ready_m[rd_req.addr] = 1'b0;
            end
            ms = regs_m[csr_pkg::CSR_ADDR_MSTATUS];
            if (trap && w.code == csr_pkg::EXC_MRET) begin
                ms[csr_pkg::MSTATUS_MIE] = ms[csr_pkg::MSTATUS_MPIE];
                ms[csr_pkg::MSTATUS_MPIE] = 1'b1;
            end else if (trap) begin
                regs_m[csr_pkg::CSR_ADDR_MEPC] = w.pc;
                regs_m[csr_pkg::CSR_ADDR_MCAUSE] = {27'd0, w.code};
                regs_m[csr_pkg::CSR_ADDR_MTVAL] = w.info;
                ms[csr_pkg::MSTATUS_MPIE] = ms[csr_pkg::MSTATUS_MIE];
                ms[csr_pkg::MSTATUS_MIE] = 1'b0;
                ms[csr_pkg::MSTATUS_MPP +: 2] = 2'b11;
            end
            regs_m[csr_pkg::CSR_ADDR_MSTATUS] = ms;
            cycle_m = cyc_n;
            instret_m = ins_n;
        end
    end

    // inputs change just after the rising edge, so the falling edge sees them settled.
    always @(negedge clk_i) begin : compare
        expect_t e;
        if (rstn_i) begin
            e = expected_outputs();
            check_data("rd_data_o", e.rd_data, rd_data_o);
            check_bit("rd_ready_o", e.rd_ready, rd_ready_o);
            check_bit("flush_o", e.redirect, flush_o);
            check_bit("redirect_valid_o", e.redirect, redirect_valid_o);
            if (e.redirect) check_pc("redirect_pc_o", e.redirect_pc, redirect_pc_o);
        end
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("simulation timed out after %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : stimulus
        logic [31:0] r;
        logic [2:0] sel;
        csr_pkg::data_t v0, v1;
        csr_pkg::tag_t t;
        csr_pkg::csr_addr_t a;
        int k;
        rstn_i = 1'b0;
        dec_exc = '0;
        exe_exc = '0;
        mem_exc = '0;
        dec_valid = 1'b0;
        exe_valid = 1'b0;
        mem_valid = 1'b0;
        rd_req = '0;
        wr_req = '0;
        rd_reserve = 1'b0;
        wr_valid = 1'b0;
        retire = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        for (int i = 0; i < 17; i++) begin
            rd_req.addr = MAPPED[i];
            step();
        end
        rd_req.addr = 12'h7C0;
        step();
        close_test("reset values");

        for (int n = 0; n < 24; n++) begin
            a = MAPPED[next_rand() % 8];
            wr_req = '{addr: a, tag: csr_pkg::tag_t'(next_rand()), data: next_rand()};
            wr_valid = 1'b1;
            step();
            rd_req.addr = a;
            step();
        end
        for (int i = 11; i < 18; i++) begin
            a = (i == 17 || i == 11) ? 12'h7C0 : MAPPED[i];
            wr_req = '{addr: a, tag: '0, data: next_rand()};
            wr_valid = 1'b1;
            step();
            rd_req.addr = a;
            step();
        end
        // reserve mepc, write with a foreign tag, then with the reserving tag.
        a = csr_pkg::CSR_ADDR_MEPC;
        t = csr_pkg::tag_t'(next_rand());
        rd_req = '{addr: a, tag: t};
        rd_reserve = 1'b1;
        step();
        step();
        wr_req = '{addr: a, tag: ~t, data: next_rand()};
        wr_valid = 1'b1;
        step();
        step();
        wr_req = '{addr: a, tag: t, data: next_rand()};
        wr_valid = 1'b1;
        step();
        step();
        close_test("write, read and scoreboard");

        for (int n = 0; n < 12; n++) begin
            wr_req = '{addr: csr_pkg::CSR_ADDR_MSTATUS, tag: '0, data: next_rand()};
            wr_valid = 1'b1;
            step();
            r = next_rand();
            sel = (r % 4 == 3) ? 3'b111 : (3'b111 & ~(3'b001 << (r % 4)));
            dec_exc = '{pc: next_rand() & 32'hFFFF_FFFC,
                        code: csr_pkg::exc_code_t'(next_rand() % 16), info: '0};
            exe_exc = '{pc: next_rand() & 32'hFFFF_FFFC,
                        code: csr_pkg::exc_code_t'(next_rand() % 16), info: next_rand()};
            mem_exc = '{pc: next_rand() & 32'hFFFF_FFFC,
                        code: csr_pkg::exc_code_t'(next_rand() % 16), info: '0};
            {mem_valid, exe_valid, dec_valid} = sel;
            step();
            for (int i = 0; i < 4; i++) begin
                rd_req.addr = (i == 3) ? csr_pkg::CSR_ADDR_MSTATUS : MAPPED[4 + i];
                step();
            end
        end
        close_test("trap priority and state");

        for (int n = 0; n < 6; n++) begin
            wr_req = '{addr: csr_pkg::CSR_ADDR_MSTATUS, tag: '0, data: next_rand()};
            wr_valid = 1'b1;
            step();
            dec_exc = '{pc: next_rand() & 32'hFFFF_FFFC, code: 5'd2, info: '0};
            dec_valid = 1'b1;
            step();
            exe_exc = '{pc: next_rand(), code: csr_pkg::EXC_MRET, info: '0};
            exe_valid = 1'b1;
            rd_req.addr = csr_pkg::CSR_ADDR_MSTATUS;
            step();
            step();
        end
        close_test("mret");

        rd_req.addr = csr_pkg::CSR_ADDR_MINSTRET;
        @(negedge clk_i);
        v0 = rd_data_o;
        step();
        k = 5 + int'(next_rand() % 20);
        for (int n = 0; n < k; n++) begin
            retire = 1'b1;
            step();
            if (next_rand() % 2 == 0) step();
        end
        @(negedge clk_i);
        v1 = rd_data_o;
        check_data("minstret delta", csr_pkg::data_t'(k), v1 - v0);
        step();
        rd_req.addr = csr_pkg::CSR_ADDR_MCYCLE;
        @(negedge clk_i);
        v0 = rd_data_o;
        k = 3 + int'(next_rand() % 30);
        repeat (k) step();
        @(negedge clk_i);
        v1 = rd_data_o;
        check_data("mcycle delta", csr_pkg::data_t'(k), v1 - v0);
        step();
        for (int i = 0; i < 2; i++) begin
            a = (i == 0) ? csr_pkg::CSR_ADDR_MCYCLEH : csr_pkg::CSR_ADDR_MINSTRET;
            wr_req = '{addr: a, tag: '0, data: next_rand()};
            wr_valid = 1'b1;
            step();
            rd_req.addr = a;
            step();
        end
        close_test("counters");

        for (int n = 0; n < 4; n++) begin
            a = (n % 2 == 0) ? csr_pkg::CSR_ADDR_MIE : csr_pkg::CSR_ADDR_MCYCLEH;
            wr_req = '{addr: a, tag: '0, data: next_rand()};
            wr_valid = 1'b1;
            exe_exc = '{pc: next_rand() & 32'hFFFF_FFFC, code: 5'd5, info: next_rand()};
            exe_valid = 1'b1;
            step();
            rd_req.addr = a;
            step();
        end
        @(negedge clk_i);
        close_test("dropped write");

        $display("summary: %0d tests ok, %0d tests bad, %0d errors", pass_cnt, fail_cnt,
                 err_cnt + int'(u_dut.u_chk.fail_count));
        if (fail_cnt == 0 && err_cnt == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: csr_trap_unit.f
csr_pkg.sv
csr_trap_arbiter.sv
csr_counters.sv
csr_regfile.sv
csr_trap_unit.sv
csr_trap_unit_chk.sv
tb_csr_trap_unit.sv
